/* logic/dwc_consts.svh */
// constants for the AXI4 write-response downsizer
// slave bursts are capped at DWC_SLV_MAX_BEATS narrow beats
// DWC_FIFO_DEPTH must be a power of two
`ifndef DWC_CONSTS_SVH
`define DWC_CONSTS_SVH

////////////////////
// channel widths
////////////////////
`define DWC_ID_W           4
`define DWC_ADDR_W         32
`define DWC_LEN_W          8

////////////////////
// width conversion
////////////////////
// narrow beats per wide beat
`define DWC_RATIO          2
`define DWC_SLV_MAX_BEATS  16
`define DWC_SLV_BYTES      4

// slave bursts allowed in flight
`define DWC_FIFO_DEPTH     4

`endif

/* logic/dwc_pkg.sv */
// types shared by the write-response downsizer
// widths come from the constants header
// user signals are not carried
`default_nettype none

`include "dwc_consts.svh"

package dwc_pkg;

   ////////////////////
   // field types
   ////////////////////
   typedef logic [`DWC_ID_W-1:0]   axi_id_t;
   typedef logic [`DWC_ADDR_W-1:0] axi_addr_t;
   // beats minus one, as on the bus
   typedef logic [`DWC_LEN_W-1:0]  axi_len_t;
   // OKAY 0, EXOKAY 1, SLVERR 2, DECERR 3
   typedef logic [1:0]             axi_resp_t;

   ////////////////////
   // channel structs
   ////////////////////
   typedef struct packed {
      axi_id_t   id;
      axi_addr_t addr;
      axi_len_t  len;
   } aw_req_t;

   // one tag per slave burst, in issue order
   typedef struct packed {
      axi_id_t id;
      logic    last;
   } bresp_tag_t;

   typedef struct packed {
      axi_id_t   id;
      axi_resp_t resp;
   } b_rsp_t;

   // splitter FSM
   typedef enum logic {
      IDLE,
      ISSUE
   } split_state_t;

endpackage

`default_nettype wire

/* logic/dwc_aw_split.sv */
// write address splitter for the downsizer
// master bursts are INCR at full master width
// no 4 KB boundary check and no wrap support
// one tag is pushed per slave burst on the s_aw transfer edge
`timescale 1ns/1ps
`default_nettype none

`include "dwc_consts.svh"

module dwc_aw_split
   import dwc_pkg::*;
(
   input  logic       ACLK,
   input  logic       sysReset,
   // master address
   input  aw_req_t    m_aw,
   input  logic       m_awvalid,
   output logic       m_awready,
   // slave address
   output aw_req_t    s_aw,
   output logic       s_awvalid,
   input  logic       s_awready,
   // tag FIFO write side
   output bresp_tag_t push_tag,
   output logic       push,
   input  logic       full
);

   // enough bits for (len+1) * ratio narrow beats
   localparam int BEATS_W = `DWC_LEN_W + $clog2(`DWC_RATIO) + 1;
   localparam logic [BEATS_W-1:0] MAX_BEATS = BEATS_W'(`DWC_SLV_MAX_BEATS);
   localparam axi_addr_t PIECE_STRIDE = axi_addr_t'(`DWC_SLV_BYTES * `DWC_SLV_MAX_BEATS);

   split_state_t        state;
   axi_id_t             req_id;
   axi_addr_t           cur_addr;
   logic [BEATS_W-1:0]  beats_left;
   logic [BEATS_W-1:0]  piece_beats;
   logic [BEATS_W-1:0]  total_beats;
   logic                last_piece;
   logic                m_xfer;
   logic                s_xfer;

   ////////////////////
   // handshakes
   ////////////////////
   // master side only takes a new address between bursts, never in reset
   assign m_awready = sysReset & (state == IDLE);
   assign m_xfer    = m_awvalid & m_awready;

   // hold off while no room for the tag
   assign s_awvalid = (state == ISSUE) & ~full;
   assign s_xfer    = s_awvalid & s_awready;
   assign push      = s_xfer;

   ////////////////////
   // piece sizing
   ////////////////////
   assign total_beats = (BEATS_W'(m_aw.len) + 1'b1) * BEATS_W'(`DWC_RATIO);

   // final piece carries whatever is left
   assign last_piece  = (beats_left <= MAX_BEATS);
   assign piece_beats = last_piece ? beats_left : MAX_BEATS;

   always_comb
   begin
      s_aw.id   = req_id;
      s_aw.addr = cur_addr;
      s_aw.len  = axi_len_t'(piece_beats - 1'b1);
   end

   assign push_tag.id   = req_id;
   assign push_tag.last = last_piece;

   ////////////////////
   // FSM
   ////////////////////
   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         state      <= IDLE;
         beats_left <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (m_xfer)
               begin
                  beats_left <= total_beats;
                  state      <= ISSUE;
               end
            end
            ISSUE:
            begin
               if (s_xfer)
               begin
                  if (last_piece)
                  begin
                     beats_left <= '0;
                     state      <= IDLE;
                  end
                  else
                  begin
                     beats_left <= beats_left - MAX_BEATS;
                  end
               end
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   // request payload, latched on accept and stepped per piece
   always_ff @(posedge ACLK)
   begin
      if (m_xfer)
      begin
         req_id   <= m_aw.id;
         cur_addr <= m_aw.addr;
      end
      else if (s_xfer && !last_piece)
      begin
         cur_addr <= cur_addr + PIECE_STRIDE;
      end
   end

endmodule

`default_nettype wire

/* logic/dwc_bresp_fifo.sv */
// tag FIFO between splitter and response merger
// DEPTH must be a power of two
// push when full and pop when empty are not guarded
// head_tag is valid only while empty is low
`timescale 1ns/1ps
`default_nettype none

`include "dwc_consts.svh"

module dwc_bresp_fifo
   import dwc_pkg::*;
#(
   parameter int DEPTH = `DWC_FIFO_DEPTH
)
(
   input  logic       ACLK,
   input  logic       sysReset,
   // write side
   input  logic       push,
   input  bresp_tag_t push_tag,
   output logic       full,
   // read side
   input  logic       pop,
   output bresp_tag_t head_tag,
   output logic       empty
);

   localparam int PTR_W = $clog2(DEPTH);

   bresp_tag_t         mem [DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   // one extra bit so full and empty differ
   logic [PTR_W:0]     count;

   assign full     = (count == (PTR_W+1)'(DEPTH));
   assign empty    = (count == '0);
   assign head_tag = mem[rd_ptr];

   ////////////////////
   // storage
   ////////////////////
   always_ff @(posedge ACLK)
   begin
      if (push)
      begin
         mem[wr_ptr] <= push_tag;
      end
   end

   ////////////////////
   // pointers and count
   ////////////////////
   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // pointers wrap naturally at power of two depth
         if (push)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/dwc_bresp_merge.sv */
// write response merger for the downsizer
// slave responses are matched to tags by order only
// the most severe code wins and is reported on the last piece
// running value restarts from OKAY after each master accept
`timescale 1ns/1ps
`default_nettype none

module dwc_bresp_merge
   import dwc_pkg::*;
(
   input  logic       ACLK,
   input  logic       sysReset,
   // slave response
   input  axi_resp_t  s_bresp,
   input  logic       s_bvalid,
   output logic       s_bready,
   // tag FIFO read side
   input  bresp_tag_t head_tag,
   input  logic       empty,
   output logic       pop,
   // master response
   output b_rsp_t     m_b,
   output logic       m_bvalid,
   input  logic       m_bready
);

   axi_resp_t resp_acc;
   axi_resp_t resp_base;
   axi_resp_t resp_fold;
   axi_id_t   bid;
   logic      m_xfer;

   ////////////////////
   // handshakes
   ////////////////////
   assign m_xfer = m_bvalid & m_bready;

   // take a slave response only with a tag waiting
   // and no master response stuck behind a low m_bready
   assign s_bready = ~empty & (~m_bvalid | m_bready);
   assign pop      = s_bvalid & s_bready;

   ////////////////////
   // severity fold
   ////////////////////
   // response leaving this cycle no longer counts
   assign resp_base = m_xfer ? '0 : resp_acc;
   // larger code is more severe
   assign resp_fold = (s_bresp > resp_base) ? s_bresp : resp_base;

   assign m_b.id   = bid;
   assign m_b.resp = resp_acc;

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         resp_acc <= '0;
         m_bvalid <= 1'b0;
      end
      else
      begin
         if (pop)
         begin
            resp_acc <= resp_fold;
            // master response goes out the cycle after the last piece
            m_bvalid <= head_tag.last;
         end
         else if (m_xfer)
         begin
            resp_acc <= '0;
            m_bvalid <= 1'b0;
         end
      end
   end

   // ID of the burst being collected
   always_ff @(posedge ACLK)
   begin
      if (pop)
      begin
         bid <= head_tag.id;
      end
   end

endmodule

`default_nettype wire

/* logic/dwc_wresp_top.sv */
// write-response side of the AXI4 downsizer
// no W channel, the slave B ID is ignored
// up to DWC_FIFO_DEPTH slave bursts may await responses
`timescale 1ns/1ps
`default_nettype none

module dwc_wresp_top
   import dwc_pkg::*;
(
   input  logic      ACLK,
   input  logic      sysReset,
   // master side
   input  aw_req_t   m_aw,
   input  logic      m_awvalid,
   output logic      m_awready,
   output b_rsp_t    m_b,
   output logic      m_bvalid,
   input  logic      m_bready,
   // slave side
   output aw_req_t   s_aw,
   output logic      s_awvalid,
   input  logic      s_awready,
   input  axi_resp_t s_bresp,
   input  logic      s_bvalid,
   output logic      s_bready
);

   bresp_tag_t push_tag;
   bresp_tag_t head_tag;
   logic       push;
   logic       full;
   logic       pop;
   logic       empty;

   ////////////////////
   // address path
   ////////////////////
   dwc_aw_split i_dwc_aw_split (
      .ACLK      (ACLK),
      .sysReset  (sysReset),
      .m_aw      (m_aw),
      .m_awvalid (m_awvalid),
      .m_awready (m_awready),
      .s_aw      (s_aw),
      .s_awvalid (s_awvalid),
      .s_awready (s_awready),
      .push_tag  (push_tag),
      .push      (push),
      .full      (full)
   );

   // tags in slave burst order
   dwc_bresp_fifo i_dwc_bresp_fifo (
      .ACLK     (ACLK),
      .sysReset (sysReset),
      .push     (push),
      .push_tag (push_tag),
      .full     (full),
      .pop      (pop),
      .head_tag (head_tag),
      .empty    (empty)
   );

   ////////////////////
   // response path
   ////////////////////
   dwc_bresp_merge i_dwc_bresp_merge (
      .ACLK     (ACLK),
      .sysReset (sysReset),
      .s_bresp  (s_bresp),
      .s_bvalid (s_bvalid),
      .s_bready (s_bready),
      .head_tag (head_tag),
      .empty    (empty),
      .pop      (pop),
      .m_b      (m_b),
      .m_bvalid (m_bvalid),
      .m_bready (m_bready)
   );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// clock and reset source for the downsizer testbench
// reset is active low and released on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 10
)
(
   output logic ACLK,
   output logic sysReset
);

   // free running clock, starts low
   initial
   begin
      ACLK = 1'b0;
      forever #(PERIOD_NS / 2) ACLK = ~ACLK;
   end

   initial
   begin
      sysReset = 1'b0;
      repeat (RESET_CYCLES) @(posedge ACLK);
      @(negedge ACLK);
      sysReset = 1'b1;
   end

endmodule

`default_nettype wire

/* verif/dwc_wresp_assertions.sv */
// protocol checks on the downsizer top-level channels
// bound into dwc_wresp_top, sees only its ports
`timescale 1ns/1ps
`default_nettype none

module dwc_wresp_assertions
   import dwc_pkg::*;
(
   input logic    ACLK,
   input logic    sysReset,
   input aw_req_t s_aw,
   input logic    s_awvalid,
   input logic    s_awready,
   input b_rsp_t  m_b,
   input logic    m_bvalid,
   input logic    m_bready
);

   // slave address stays up and unchanged until accepted
   saw_hold: assert property (@(posedge ACLK) disable iff (!sysReset)
      s_awvalid && !s_awready |=> s_awvalid && $stable(s_aw))
      else $error("s_aw dropped or changed while s_awready was low");

   // master response waits unchanged under m_bready low
   mb_hold: assert property (@(posedge ACLK) disable iff (!sysReset)
      m_bvalid && !m_bready |=> m_bvalid && $stable(m_b))
      else $error("m_b dropped or changed while m_bready was low");

   // no valid out of reset
   reset_quiet: assert property (@(posedge ACLK)
      !sysReset |-> !s_awvalid && !m_bvalid)
      else $error("valid raised while sysReset was asserted");

endmodule

`default_nettype wire

/* verif/dwc_wresp_tb.sv */
// testbench for the write-response side of the downsizer
// inputs change on the falling edge, outputs are sampled on the rising edge
// slave model answers in issue order, stalls come from a seeded xorshift
// expected slave bursts and merged responses come from the splitting rule
`timescale 1ns/1ps
`include "dwc_consts.svh"
`default_nettype none

module dwc_wresp_tb
   import dwc_pkg::*;
;

   localparam int RESET_CYCLES = 10;
   localparam int NUM_BURSTS   = 29;
   localparam int TIMEOUT_NS   = (NUM_BURSTS * 400 + RESET_CYCLES) * 8;

   // one expected slave burst
   typedef struct packed {
      aw_req_t aw;
      logic    last;
   } piece_t;

   logic        ACLK;
   logic        sysReset;
   aw_req_t     m_aw;
   logic        m_awvalid;
   logic        m_awready;
   b_rsp_t      m_b;
   logic        m_bvalid;
   logic        m_bready;
   aw_req_t     s_aw;
   logic        s_awvalid;
   logic        s_awready;
   axi_resp_t   s_bresp;
   logic        s_bvalid;
   logic        s_bready;

   logic [31:0] rng_state     = 32'd62;
   string       test_name     = "reset";
   int          error_count   = 0;
   int          check_count   = 0;
   int          m_req_count   = 0;
   int          m_resp_count  = 0;
   int          s_aw_count    = 0;
   int          s_b_count     = 0;
   int          hold_left     = 0;
   int          b_gap         = 0;
   logic        stall_on      = 1'b0;
   logic        bready_random = 1'b0;
   piece_t      exp_pieces[$];
   b_rsp_t      exp_b_q[$];
   axi_resp_t   slave_resp_q[$];
   axi_resp_t   forced_resp_q[$];
   axi_resp_t   merge_acc     = 2'd0;
   piece_t      cur_piece;
   b_rsp_t      cur_b;
   axi_resp_t   cur_resp;
   aw_req_t     held_aw;
   b_rsp_t      held_b;
   logic        aw_waiting    = 1'b0;
   logic        b_waiting     = 1'b0;

   tb_clock_gen #(
      .PERIOD_NS    (8),
      .RESET_CYCLES (RESET_CYCLES)
   ) i_tb_clock_gen (
      .ACLK     (ACLK),
      .sysReset (sysReset)
   );

   dwc_wresp_top i_dwc_wresp_top (.*);

   bind dwc_wresp_top dwc_wresp_assertions i_dwc_wresp_assertions (
      .ACLK      (ACLK),
      .sysReset  (sysReset),
      .s_aw      (s_aw),
      .s_awvalid (s_awvalid),
      .s_awready (s_awready),
      .m_b       (m_b),
      .m_bvalid  (m_bvalid),
      .m_bready  (m_bready)
   );

   ////////////////////
   // helpers
   ////////////////////
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // slave bursts for one master burst, 16 narrow beats at most each
   function automatic int piece_total(input axi_len_t len);
      int beats;
      beats = (int'(len) + 1) * `DWC_RATIO;
      return (beats + `DWC_SLV_MAX_BEATS - 1) / `DWC_SLV_MAX_BEATS;
   endfunction

   // piece k of a master burst, last piece takes the remainder
   function automatic piece_t ref_piece(input aw_req_t req, input int k);
      piece_t p;
      int     beats;
      int     count;
      count = piece_total(req.len);
      beats = (int'(req.len) + 1) * `DWC_RATIO;
      if (k != count - 1)
         beats = `DWC_SLV_MAX_BEATS;
      else
         beats = beats - k * `DWC_SLV_MAX_BEATS;
      p.aw.id   = req.id;
      p.aw.addr = req.addr + axi_addr_t'(k * `DWC_SLV_BYTES * `DWC_SLV_MAX_BEATS);
      p.aw.len  = axi_len_t'(beats - 1);
      p.last    = (k == count - 1);
      return p;
   endfunction

   // larger code is more severe
   function automatic axi_resp_t worst_resp(input axi_resp_t a, input axi_resp_t b);
      return (a > b) ? a : b;
   endfunction

   task automatic check_value(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("mismatch %s %s: expected %0h actual %0h",
                  test_name, what, expected, actual);
      end
   endtask

   // called on a falling edge, returns on a falling edge
   task automatic send_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len);
      m_aw.id   = id;
      m_aw.addr = addr;
      m_aw.len  = len;
      m_awvalid = 1'b1;
      do
         @(posedge ACLK);
      while (!m_awready);
      @(negedge ACLK);
      m_awvalid = 1'b0;
   endtask

   task automatic wait_done();
      while (m_resp_count < m_req_count || exp_pieces.size() != 0)
         @(posedge ACLK);
      @(negedge ACLK);
   endtask

   ////////////////////
   // test sequence
   ////////////////////
   initial
   begin
      m_aw      = '0;
      m_awvalid = 1'b0;
      wait (sysReset === 1'b1);
      @(negedge ACLK);

      test_name = "single_beat";
      send_burst(4'h3, 32'h0000_1000, 8'd0);
      send_burst(4'hc, 32'h0000_2040, 8'd0);
      wait_done();

      // 64 beats in four full pieces, then 42 beats ending in a short piece
      test_name = "long_burst";
      send_burst(4'h5, 32'h0001_0000, 8'd31);
      send_burst(4'h6, 32'h0002_0000, 8'd20);
      wait_done();

      // SLVERR wins, then DECERR wins, then an all OKAY burst
      test_name = "merge_max";
      forced_resp_q = '{2'd0, 2'd2, 2'd1, 2'd0, 2'd1, 2'd3, 2'd0, 2'd2, 2'd0};
      send_burst(4'h1, 32'h0003_0000, 8'd31);
      send_burst(4'h2, 32'h0004_0000, 8'd31);
      send_burst(4'h3, 32'h0005_0000, 8'd7);
      wait_done();

      test_name = "back_to_back";
      stall_on  = 1'b1;
      for (int i = 0; i < 12; i++)
         send_burst(axi_id_t'(i), next_rand() & 32'h00ff_ffc0, axi_len_t'(next_rand() % 32));
      wait_done();

      test_name     = "bready_hold";
      bready_random = 1'b1;
      for (int i = 0; i < 10; i++)
         send_burst(axi_id_t'(15 - i), next_rand() & 32'h00ff_ffc0,
                    axi_len_t'(next_rand() % 32));
      wait_done();
      bready_random = 1'b0;

      test_name = "drain";
      check_value("pending slave responses", 64'd0, 64'(slave_resp_q.size()));
      check_value("slave responses accepted", 64'(s_aw_count), 64'(s_b_count));
      $display("bursts %0d checks %0d errors %0d", m_resp_count, check_count, error_count);
      if (error_count == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   ////////////////////
   // slave model
   ////////////////////
   initial
   begin
      s_awready = 1'b0;
      forever
      begin
         @(negedge ACLK);
         s_awready = !stall_on || (next_rand() % 3 != 0);
      end
   end

   // responses go back in issue order, one at a time
   initial
   begin
      s_bvalid = 1'b0;
      s_bresp  = '0;
      forever
      begin
         @(negedge ACLK);
         if (b_gap != 0)
            b_gap--;
         else if (slave_resp_q.size() != 0)
         begin
            s_bresp  = slave_resp_q.pop_front();
            s_bvalid = 1'b1;
            do
               @(posedge ACLK);
            while (!s_bready);
            s_b_count++;
            @(negedge ACLK);
            s_bvalid = 1'b0;
            b_gap    = stall_on ? int'(next_rand() % 5) : 0;
         end
      end
   end

   // master response ready, random low stretches in the last test
   initial
   begin
      m_bready = 1'b0;
      forever
      begin
         @(negedge ACLK);
         if (!bready_random)
            m_bready = 1'b1;
         else if (hold_left == 0)
         begin
            m_bready  = (next_rand() % 2 == 0);
            hold_left = int'(next_rand() % 10);
         end
         else
            hold_left--;
      end
   end

   ////////////////////
   // compare process
   ////////////////////
   initial
   begin
      forever
      begin
         @(posedge ACLK);
         if (sysReset !== 1'b1)
         begin
            check_value("s_awvalid in reset", 64'd0, 64'(s_awvalid));
            check_value("m_bvalid in reset", 64'd0, 64'(m_bvalid));
            check_value("m_awready in reset", 64'd0, 64'(m_awready));
            check_value("s_bready in reset", 64'd0, 64'(s_bready));
         end
         else
         begin
            // stalled channels must hold
            if (aw_waiting)
            begin
               check_value("s_awvalid held", 64'd1, 64'(s_awvalid));
               check_value("s_aw held", 64'(held_aw), 64'(s_aw));
            end
            if (b_waiting)
            begin
               check_value("m_bvalid held", 64'd1, 64'(m_bvalid));
               check_value("m_b held", 64'(held_b), 64'(m_b));
            end

            // new master address only once every piece of the last one went out
            check_value("m_awready", 64'(exp_pieces.size() == 0), 64'(m_awready));

            // no slave response taken while a master response waits
            if (m_bvalid && !m_bready)
            begin
               check_value("s_bready under hold", 64'd0, 64'(s_bready));
            end

            if (m_awvalid && m_awready)
            begin
               for (int k = 0; k < piece_total(m_aw.len); k++)
                  exp_pieces.push_back(ref_piece(m_aw, k));
               m_req_count++;
            end

            if (s_awvalid && s_awready)
            begin
               s_aw_count++;
               if (exp_pieces.size() == 0)
               begin
                  error_count++;
                  $display("error: %s slave address issued with no burst pending", test_name);
               end
               else
               begin
                  cur_piece = exp_pieces.pop_front();
                  check_value("s_aw id", 64'(cur_piece.aw.id), 64'(s_aw.id));
                  check_value("s_aw addr", 64'(cur_piece.aw.addr), 64'(s_aw.addr));
                  check_value("s_aw len", 64'(cur_piece.aw.len), 64'(s_aw.len));
                  if (forced_resp_q.size() != 0)
                     cur_resp = forced_resp_q.pop_front();
                  else
                     cur_resp = axi_resp_t'(next_rand() % 4);
                  slave_resp_q.push_back(cur_resp);
                  merge_acc = worst_resp(merge_acc, cur_resp);
                  if (cur_piece.last)
                  begin
                     cur_b.id   = cur_piece.aw.id;
                     cur_b.resp = merge_acc;
                     exp_b_q.push_back(cur_b);
                     merge_acc  = 2'd0;
                  end
               end
            end

            if (m_bvalid && m_bready)
            begin
               m_resp_count++;
               if (exp_b_q.size() == 0)
               begin
                  error_count++;
                  $display("error: %s master response with no burst outstanding", test_name);
               end
               else
               begin
                  cur_b = exp_b_q.pop_front();
                  check_value("m_b id", 64'(cur_b.id), 64'(m_b.id));
                  check_value("m_b resp", 64'(cur_b.resp), 64'(m_b.resp));
               end
            end
         end
         aw_waiting = (sysReset === 1'b1) && s_awvalid && !s_awready;
         b_waiting  = (sysReset === 1'b1) && m_bvalid && !m_bready;
         held_aw    = s_aw;
         held_b     = m_b;
      end
   end

   ////////////////////
   // watchdog
   ////////////////////
   initial
   begin
      #(TIMEOUT_NS);
      $display("error: watchdog expired after %0d ns in %s, DUT stopped responding",
               TIMEOUT_NS, test_name);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* dwc_wresp_top.f */
+incdir+logic
logic/dwc_pkg.sv
logic/dwc_aw_split.sv
logic/dwc_bresp_fifo.sv
logic/dwc_bresp_merge.sv
logic/dwc_wresp_top.sv
verif/tb_clock_gen.sv
verif/dwc_wresp_assertions.sv
verif/dwc_wresp_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the downsizer testbench with Verilator
# the result is decided by searching sim.log

rm -rf obj_dir sim.log

verilator --binary --timing -f dwc_wresp_top.f --top-module dwc_wresp_tb \
   || { echo "verilator build failed"; exit 1; }

./obj_dir/Vdwc_wresp_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
